//--- design/dcache_params.svh
/*
 * dcache geometry, field widths and the flush hit-count address
 */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cache geometry
`define DC_SETS 8
`define DC_WAYS 2

// word and address field widths
`define DC_WORD_W 32
`define DC_TAG_W 26
`define DC_INDEX_W 3

// the flush ends with one write of the hit count here
`define HIT_COUNT_ADDR 32'h3100

`endif

//--- design/dcache_pkg.sv
/*
 * dcache types: the request address, seen as a plain word or as
 * tag, index and offset fields
 */
`include "dcache_params.svh"

package dcache_pkg;

	typedef union packed {
		logic [`DC_WORD_W-1:0] word; // full byte address
		struct packed {
			logic [`DC_TAG_W-1:0]   tag;
			logic [`DC_INDEX_W-1:0] index; // set select
			logic                   word_off; // word within block
			logic [1:0]             byte_off; // ignored, word access only
		} fields;
	} dc_addr_t;

endpackage

//--- design/frame_store.sv
/*
 * frame store: valid, dirty, tag and two data words for every way
 * of every set, one combinational set read and one write port
 */
`include "dcache_params.svh"

module frame_store (
	input  logic                                         CLK,
	input  logic                                         nRST,
	input  logic [`DC_INDEX_W-1:0]                       set_index,
	input  logic                                         wr_way,
	input  logic                                         wr_word,
	input  logic [`DC_WORD_W-1:0]                        wr_data,
	input  logic                                         fill_en,
	input  logic                                         tag_en,
	input  logic                                         store_en,
	input  logic                                         clean_en,
	input  logic [`DC_TAG_W-1:0]                         wr_tag,
	output logic [`DC_WAYS-1:0]                          set_valid,
	output logic [`DC_WAYS-1:0]                          set_dirty,
	output logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]           set_tag,
	output logic [`DC_WAYS-1:0][1:0][`DC_WORD_W-1:0]     set_data
);

	logic [`DC_SETS-1:0][`DC_WAYS-1:0]                      valid_q;
	logic [`DC_SETS-1:0][`DC_WAYS-1:0]                      dirty_q;
	logic [`DC_SETS-1:0][`DC_WAYS-1:0][`DC_TAG_W-1:0]       tag_q;
	logic [`DC_SETS-1:0][`DC_WAYS-1:0][1:0][`DC_WORD_W-1:0] data_q;

	// status bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (tag_en) begin
				valid_q[set_index][wr_way] <= 1'b1; // new block allocated
			end
			if (tag_en || clean_en) begin
				dirty_q[set_index][wr_way] <= 1'b0;
			end
			if (store_en) begin
				dirty_q[set_index][wr_way] <= 1'b1; // block differs from memory
			end
		end
	end

	// tag and data arrays
	always_ff @(posedge CLK) begin
		if (tag_en) begin
			tag_q[set_index][wr_way] <= wr_tag;
		end
		if (fill_en || store_en) begin
			data_q[set_index][wr_way][wr_word] <= wr_data;
		end
	end

	assign set_valid = valid_q[set_index];
	assign set_dirty = dirty_q[set_index];
	assign set_tag   = tag_q[set_index];
	assign set_data  = data_q[set_index];

endmodule

//--- design/hit_check.sv
/*
 * hit check: tag compare across both ways, victim choice and the
 * per-set least-recently-filled bits
 */
`include "dcache_params.svh"

module hit_check import dcache_pkg::*; (
	input  logic                               CLK,
	input  logic                               nRST,
	input  dc_addr_t                           addr,
	input  logic [`DC_WAYS-1:0]                set_valid,
	input  logic [`DC_WAYS-1:0]                set_dirty,
	input  logic [`DC_WAYS-1:0][`DC_TAG_W-1:0] set_tag,
	input  logic                               touch_en,
	input  logic                               touch_way,
	output logic                               hit,
	output logic                               hit_way,
	output logic                               victim_way,
	output logic                               victim_dirty
);

	logic [`DC_SETS-1:0] repl_q; // way to replace next, per set
	logic [`DC_WAYS-1:0] match;

	genvar w;
	generate
		for (w = 0; w < `DC_WAYS; w++) begin : g_cmp
			assign match[w] = set_valid[w] && (set_tag[w] == addr.fields.tag);
		end
	endgenerate

	assign hit     = |match;
	assign hit_way = !match[0]; // only meaningful with hit

	// an empty way is always taken before any valid block is evicted
	always_comb begin
		if (!set_valid[0]) begin
			victim_way = 1'b0;
		end else if (!set_valid[1]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = repl_q[addr.fields.index];
		end
	end

	assign victim_dirty = set_dirty[victim_way];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			repl_q <= '0;
		end else if (touch_en) begin
			repl_q[addr.fields.index] <= !touch_way; // other way is now older
		end
	end

endmodule

//--- design/cache_controller.sv
/*
 * dcache controller: serves hits in idle, runs write-back and fill on
 * a miss, and walks every frame on halt before writing the hit count
 */
`include "dcache_params.svh"

module cache_controller import dcache_pkg::*; (
	input  logic                                     CLK,
	input  logic                                     nRST,
	input  dc_addr_t                                 dmem_addr,
	input  logic                                     dmem_ren,
	input  logic                                     dmem_wen,
	input  logic [`DC_WORD_W-1:0]                    dmem_store,
	input  logic                                     halt,
	input  logic                                     hit,
	input  logic                                     hit_way,
	input  logic                                     victim_way,
	input  logic                                     victim_dirty,
	input  logic [`DC_WAYS-1:0]                      set_valid,
	input  logic [`DC_WAYS-1:0]                      set_dirty,
	input  logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]       set_tag,
	input  logic [`DC_WAYS-1:0][1:0][`DC_WORD_W-1:0] set_data,
	input  logic [`DC_WORD_W-1:0]                    mem_load,
	input  logic                                     mem_wait,
	output logic                                     dhit,
	output logic [`DC_WORD_W-1:0]                    dmem_load,
	output logic                                     flushed,
	output logic [`DC_INDEX_W-1:0]                   set_index,
	output logic                                     wr_way,
	output logic                                     wr_word,
	output logic [`DC_WORD_W-1:0]                    wr_data,
	output logic [`DC_TAG_W-1:0]                     wr_tag,
	output logic                                     fill_en,
	output logic                                     tag_en,
	output logic                                     store_en,
	output logic                                     clean_en,
	output logic                                     touch_en,
	output logic                                     touch_way,
	output logic                                     mem_ren,
	output logic                                     mem_wen,
	output logic [`DC_WORD_W-1:0]                    mem_addr,
	output logic [`DC_WORD_W-1:0]                    mem_store
);

	typedef enum logic [3:0] {
		st_idle,
		st_wb0,
		st_wb1,
		st_fill0,
		st_fill1,
		st_flush_scan,
		st_flush_hi,
		st_hit_write,
		st_done
	} state_t;

	state_t                  state, next_state;
	logic                    victim_q; // way being replaced
	logic [`DC_INDEX_W:0]    frame_cnt; // {set, way} during flush
	logic [`DC_WORD_W-1:0]   hit_count;
	logic                    latch_victim, frame_inc, count_hit;
	logic                    req, req_word, acc_way;
	logic                    flush_way, last_frame;
	logic [`DC_INDEX_W-1:0]  flush_set;

	assign req        = dmem_ren || dmem_wen;
	assign req_word   = dmem_addr.fields.word_off;
	assign flush_way  = frame_cnt[0];
	assign flush_set  = frame_cnt[`DC_INDEX_W:1];
	assign last_frame = &frame_cnt;
	assign acc_way    = (state == st_idle) ? hit_way : victim_q;
	assign flushed    = (state == st_done);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= st_idle;
			victim_q  <= 1'b0;
			frame_cnt <= '0;
			hit_count <= '0;
		end else begin
			state <= next_state;
			if (latch_victim) begin
				victim_q <= victim_way;
			end
			if (frame_inc) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			if (count_hit) begin
				hit_count <= hit_count + 1'b1;
			end
		end
	end

	always_comb begin
		next_state   = state;
		latch_victim = 1'b0;
		frame_inc    = 1'b0;
		count_hit    = 1'b0;
		dhit         = 1'b0;
		dmem_load    = set_data[acc_way][req_word];
		set_index    = dmem_addr.fields.index;
		wr_way       = victim_q;
		wr_word      = req_word;
		wr_data      = mem_load;
		wr_tag       = dmem_addr.fields.tag;
		fill_en      = 1'b0;
		tag_en       = 1'b0;
		store_en     = 1'b0;
		clean_en     = 1'b0;
		touch_en     = 1'b0;
		touch_way    = victim_q;
		mem_ren      = 1'b0;
		mem_wen      = 1'b0;
		mem_addr     = '0;
		mem_store    = '0;

		case (state)
			st_idle: begin
				if (req) begin
					if (hit) begin
						dhit      = 1'b1;
						count_hit = 1'b1;
						if (dmem_wen) begin
							store_en = 1'b1; // write hit, lands at this edge
							wr_way   = hit_way;
							wr_data  = dmem_store;
						end
					end else begin
						latch_victim = 1'b1;
						next_state   = victim_dirty ? st_wb0 : st_fill0;
					end
				end else if (halt) begin
					next_state = st_flush_scan;
				end
			end
			st_wb0: begin
				mem_wen   = 1'b1;
				mem_addr  = {set_tag[victim_q], set_index, 1'b0, 2'b00};
				mem_store = set_data[victim_q][0];
				if (!mem_wait) begin
					next_state = st_wb1;
				end
			end
			st_wb1: begin
				mem_wen   = 1'b1;
				mem_addr  = {set_tag[victim_q], set_index, 1'b1, 2'b00};
				mem_store = set_data[victim_q][1];
				if (!mem_wait) begin
					clean_en   = 1'b1;
					next_state = st_fill0;
				end
			end
			st_fill0: begin
				mem_ren  = 1'b1;
				mem_addr = {dmem_addr.word[`DC_WORD_W-1:2], 2'b00}; // requested word
				if (!mem_wait) begin
					tag_en  = 1'b1;
					fill_en = 1'b1;
					// a write miss keeps its own word instead of memory's
					wr_data = dmem_wen ? dmem_store : mem_load;
					next_state = st_fill1;
				end
			end
			st_fill1: begin
				mem_ren  = 1'b1;
				mem_addr = {dmem_addr.word[`DC_WORD_W-1:3], !req_word, 2'b00};
				if (!mem_wait) begin
					wr_word = !req_word;
					// store_en also marks the block dirty for a write miss
					fill_en    = !dmem_wen;
					store_en   = dmem_wen;
					dhit       = 1'b1;
					touch_en   = 1'b1;
					next_state = st_idle;
				end
			end
			st_flush_scan: begin
				set_index = flush_set;
				if (set_valid[flush_way] && set_dirty[flush_way]) begin
					mem_wen   = 1'b1;
					mem_addr  = {set_tag[flush_way], flush_set, 1'b0, 2'b00};
					mem_store = set_data[flush_way][0];
					if (!mem_wait) begin
						next_state = st_flush_hi;
					end
				end else if (last_frame) begin
					next_state = st_hit_write;
				end else begin
					frame_inc = 1'b1; // clean frame, skip
				end
			end
			st_flush_hi: begin
				set_index = flush_set;
				mem_wen   = 1'b1;
				mem_addr  = {set_tag[flush_way], flush_set, 1'b1, 2'b00};
				mem_store = set_data[flush_way][1];
				if (!mem_wait) begin
					if (last_frame) begin
						next_state = st_hit_write;
					end else begin
						frame_inc  = 1'b1;
						next_state = st_flush_scan;
					end
				end
			end
			st_hit_write: begin
				mem_wen   = 1'b1;
				mem_addr  = `HIT_COUNT_ADDR;
				mem_store = hit_count;
				if (!mem_wait) begin
					next_state = st_done;
				end
			end
			st_done: begin
				next_state = st_done; // held until reset
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

endmodule

//--- design/dcache_top.sv
/*
 * dcache top: frame store, hit check and controller between the
 * processor load/store port and the word-wide memory bus
 */
`include "dcache_params.svh"

module dcache_top import dcache_pkg::*; (
	input  logic                  CLK,
	input  logic                  nRST,
	input  dc_addr_t              dmem_addr,
	input  logic                  dmem_ren,
	input  logic                  dmem_wen,
	input  logic [`DC_WORD_W-1:0] dmem_store,
	input  logic                  halt,
	output logic                  dhit,
	output logic [`DC_WORD_W-1:0] dmem_load,
	output logic                  flushed,
	output logic                  mem_ren,
	output logic                  mem_wen,
	output logic [`DC_WORD_W-1:0] mem_addr,
	output logic [`DC_WORD_W-1:0] mem_store,
	input  logic [`DC_WORD_W-1:0] mem_load,
	input  logic                  mem_wait
);

	// set read, shared by hit check and controller
	logic [`DC_INDEX_W-1:0]                   set_index;
	logic [`DC_WAYS-1:0]                      set_valid, set_dirty;
	logic [`DC_WAYS-1:0][`DC_TAG_W-1:0]       set_tag;
	logic [`DC_WAYS-1:0][1:0][`DC_WORD_W-1:0] set_data;

	// frame write port
	logic                  wr_way, wr_word;
	logic [`DC_WORD_W-1:0] wr_data;
	logic [`DC_TAG_W-1:0]  wr_tag;
	logic                  fill_en, tag_en, store_en, clean_en;

	logic hit, hit_way, victim_way, victim_dirty;
	logic touch_en, touch_way;

	frame_store u_store (
		.CLK, .nRST, .set_index, .wr_way, .wr_word, .wr_data,
		.fill_en, .tag_en, .store_en, .clean_en, .wr_tag,
		.set_valid, .set_dirty, .set_tag, .set_data
	);

	hit_check u_check (
		.CLK, .nRST, .addr(dmem_addr), .set_valid, .set_dirty, .set_tag,
		.touch_en, .touch_way, .hit, .hit_way, .victim_way, .victim_dirty
	);

	cache_controller u_ctrl (
		.CLK, .nRST, .dmem_addr, .dmem_ren, .dmem_wen, .dmem_store, .halt,
		.hit, .hit_way, .victim_way, .victim_dirty,
		.set_valid, .set_dirty, .set_tag, .set_data, .mem_load, .mem_wait,
		.dhit, .dmem_load, .flushed, .set_index,
		.wr_way, .wr_word, .wr_data, .wr_tag,
		.fill_en, .tag_en, .store_en, .clean_en, .touch_en, .touch_way,
		.mem_ren, .mem_wen, .mem_addr, .mem_store
	);

endmodule

//--- tests/dcache_properties.sv
/*
 * dcache controller properties: bus direction, stall stability and
 * flush status, bound into the controller
 */
`include "dcache_params.svh"

module dcache_properties (
	input logic                  CLK,
	input logic                  nRST,
	input logic                  mem_ren,
	input logic                  mem_wen,
	input logic                  mem_wait,
	input logic [`DC_WORD_W-1:0] mem_addr,
	input logic [`DC_WORD_W-1:0] mem_store,
	input logic                  dhit,
	input logic                  flushed
);

	int fail_count = 0; // read by the testbench at the end

	a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
	else begin
		$error("memory read and write requested together");
		fail_count++;
	end

	// a stalled transfer keeps its bus outputs
	a_hold: assert property (@(posedge CLK) disable iff (!nRST)
		(mem_wait && (mem_ren || mem_wen)) |=> ($stable(mem_ren) && $stable(mem_wen)
			&& $stable(mem_addr) && $stable(mem_store)))
	else begin
		$error("bus outputs changed during a stall");
		fail_count++;
	end

	a_flushed_held: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
	else begin
		$error("flushed fell after rising");
		fail_count++;
	end

	a_no_hit_flushed: assert property (@(posedge CLK) disable iff (!nRST) !(dhit && flushed))
	else begin
		$error("dhit while flushed");
		fail_count++;
	end

endmodule

bind cache_controller dcache_properties props (.*);

//--- tests/dcache_checker.sv
/*
 * dcache checker: reference tags, valid, dirty and replacement bits with
 * a shadow memory, compared against each completed request and the flush
 */
`include "dcache_params.svh"

module dcache_checker #(parameter logic [31:0] INIT_XOR = 32'hC0DE0000) (
	input  logic        CLK,
	input  logic        nRST,
	input  logic [31:0] dmem_addr,
	input  logic        dmem_ren, dmem_wen,
	input  logic [31:0] dmem_store, dmem_load,
	input  logic        dhit, flushed,
	input  logic        mem_ren, mem_wen, mem_wait,
	input  logic [31:0] mem_addr, mem_store,
	output logic        done,
	output int          tests_run,
	output int          error_count
);

	logic [`DC_TAG_W-1:0] ref_tag [`DC_SETS][2];
	logic [1:0]           ref_valid [`DC_SETS];
	logic [1:0]           ref_dirty [`DC_SETS];
	logic                 ref_repl [`DC_SETS]; // way to refill next
	logic [31:0]          ref_mem [logic [31:0]]; // last processor store per word
	logic [31:0]          bus_mem [logic [31:0]]; // words written on the memory bus
	int                   hits, stall_cycles;
	int                   fill_reads, wb_writes; // bus transfers of the pending request

	task automatic report_error(string msg);
		$display("error %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic serve_request();
		logic [31:0]            a, want;
		logic [`DC_INDEX_W-1:0] s;
		logic [`DC_TAG_W-1:0]   t;
		logic                   way, found, evict;
		string                  note;
		a = {dmem_addr[31:2], 2'b00};
		s = a[`DC_INDEX_W+2:3];
		t = a[31:`DC_INDEX_W+3];
		found = (ref_valid[s][0] && ref_tag[s][0] == t)
			|| (ref_valid[s][1] && ref_tag[s][1] == t);
		way = !(ref_valid[s][0] && ref_tag[s][0] == t);
		evict = 1'b0;
		note = "";
		if (found) begin
			hits++;
			if (stall_cycles != 0) begin
				report_error($sformatf("hit at %h took %0d extra cycles",
					a, stall_cycles));
			end
		end else begin
			if (stall_cycles == 0) begin
				report_error($sformatf("miss at %h answered without a fill", a));
			end
			way = !ref_valid[s][0] ? 1'b0 : !ref_valid[s][1] ? 1'b1 : ref_repl[s];
			evict = ref_valid[s][way] && ref_dirty[s][way];
			if (evict) begin
				note = ", dirty block evicted";
			end
			ref_tag[s][way]   = t;
			ref_valid[s][way] = 1'b1;
			ref_dirty[s][way] = 1'b0;
			ref_repl[s]       = !way; // least recently filled
		end
		// a miss reads both block words, after writing both back if dirty
		if (fill_reads != (found ? 0 : 2)) begin
			report_error($sformatf("%h made %0d memory reads, expected %0d",
				a, fill_reads, found ? 0 : 2));
		end
		if (wb_writes != (evict ? 2 : 0)) begin
			report_error($sformatf("%h made %0d write-backs, expected %0d",
				a, wb_writes, evict ? 2 : 0));
		end
		if (dmem_wen) begin
			ref_mem[a]        = dmem_store;
			ref_dirty[s][way] = 1'b1;
		end else begin
			want = ref_mem.exists(a) ? ref_mem[a] : a ^ INIT_XOR;
			if (dmem_load !== want) begin
				report_error($sformatf("read %h returned %h, expected %h",
					a, dmem_load, want));
			end
		end
		tests_run++;
		$display("%s %h: %s%s", dmem_wen ? "write" : "read", a, found ? "hit" : "miss", note);
	endtask

	task automatic check_flush();
		int bad;
		bad = 0;
		foreach (ref_mem[k]) begin
			if (!bus_mem.exists(k)) begin
				$display("address %h was stored but never reached memory", k);
				error_count++;
				bad++;
			end else if (bus_mem[k] !== ref_mem[k]) begin
				report_error($sformatf("memory %h holds %h, expected %h",
					k, bus_mem[k], ref_mem[k]));
				bad++;
			end
		end
		tests_run++;
		$display("flush: %0d stored words checked, %0d wrong", ref_mem.num(), bad);
		if (!bus_mem.exists(`HIT_COUNT_ADDR)) begin
			$display("hit count was never written to memory");
			error_count++;
		end else if (bus_mem[`HIT_COUNT_ADDR] !== hits) begin
			report_error($sformatf("hit count %0d, expected %0d",
				bus_mem[`HIT_COUNT_ADDR], hits));
		end
		tests_run++;
		$display("hit count: %0d expected", hits);
	endtask

	// sampled mid-cycle, away from the edges where inputs change
	always @(negedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < `DC_SETS; i++) begin
				ref_valid[i] = '0;
				ref_dirty[i] = '0;
				ref_repl[i]  = 1'b0;
			end
			hits         = 0;
			stall_cycles = 0;
			fill_reads   = 0;
			wb_writes    = 0;
			tests_run    = 0;
			error_count  = 0;
			done         = 1'b0;
		end else begin
			if (mem_wen && !mem_wait) begin
				bus_mem[mem_addr] = mem_store;
				if (dmem_ren || dmem_wen) begin
					wb_writes++;
				end
			end
			if (mem_ren && !mem_wait) begin
				if (!(dmem_ren || dmem_wen)) begin
					$display("memory read of %h with no request pending", mem_addr);
					error_count++;
				end else if (mem_addr[31:3] != dmem_addr[31:3]) begin
					report_error($sformatf("memory read %h outside requested block %h",
						mem_addr, dmem_addr));
				end
				fill_reads++;
			end
			if (dhit) begin
				serve_request();
				stall_cycles = 0;
				fill_reads   = 0;
				wb_writes    = 0;
			end else if (dmem_ren || dmem_wen) begin
				stall_cycles++;
			end
			if (flushed && !done) begin
				check_flush();
				done = 1'b1;
			end
		end
	end

endmodule

//--- tests/tb_dcache.sv
/*
 * dcache testbench: runs the pattern file against the DUT with a
 * randomly stalling memory model behind it
 */
`include "dcache_params.svh"

module tb_dcache import dcache_pkg::*; ();

	localparam logic [31:0] INIT_XOR = 32'hC0DE0000; // unwritten word is address ^ this
	localparam logic [31:0] SEED     = 32'ha87f4683;

	logic        CLK, nRST, dmem_ren, dmem_wen, halt, dhit, flushed;
	logic        mem_ren, mem_wen, chk_done, loaded;
	logic        mem_wait = 1'b1;
	logic [31:0] mem_load = '0;
	logic [31:0] dmem_store, dmem_load, mem_addr, mem_store;
	dc_addr_t    dmem_addr;
	logic [31:0] mem_model [logic [31:0]];
	string       op_kind [$];
	logic [31:0] op_addr [$], op_data [$];
	int          delay_left = 0;
	int          chk_tests, chk_errors, n_ops;

	dcache_top DUT (.*);

	dcache_checker #(.INIT_XOR(INIT_XOR)) chk (
		.CLK, .nRST, .dmem_addr, .dmem_ren, .dmem_wen, .dmem_store, .dmem_load,
		.dhit, .flushed, .mem_ren, .mem_wen, .mem_wait, .mem_addr, .mem_store,
		.done(chk_done), .tests_run(chk_tests), .error_count(chk_errors)
	);

	always #2 CLK = ~CLK;

	// a transfer is seen at one edge, then stalls 0 to 3 more cycles
	always @(posedge CLK) begin
		if (mem_ren || mem_wen) begin
			if (!mem_wait) begin
				if (mem_wen) begin
					mem_model[mem_addr] = mem_store;
				end
				mem_wait   <= 1'b1;
				delay_left <= int'($urandom % 4);
			end else if (delay_left == 0) begin
				mem_wait <= 1'b0;
				mem_load <= mem_model.exists(mem_addr) ? mem_model[mem_addr]
					: mem_addr ^ INIT_XOR;
			end else begin
				delay_left <= delay_left - 1;
			end
		end
	end

	function automatic bit read_patterns();
		int          fd;
		string       line, kind;
		logic [31:0] a, d;
		fd = $fopen("tests/dcache_patterns.txt", "r");
		if (fd == 0) begin
			return 1'b0;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.substr(0, 0) != "#"
				&& $sscanf(line, "%s %h %h", kind, a, d) == 3) begin
				op_kind.push_back(kind);
				op_addr.push_back(a);
				op_data.push_back(d);
			end
		end
		$fclose(fd);
		return 1'b1;
	endfunction

	task automatic run_op(string kind, logic [31:0] a, logic [31:0] d);
		@(posedge CLK);
		if (kind == "halt") begin
			halt <= 1'b1;
			do @(negedge CLK); while (!flushed);
		end else begin
			dmem_addr  <= a;
			dmem_ren   <= (kind == "read");
			dmem_wen   <= (kind == "write");
			dmem_store <= d;
			do @(negedge CLK); while (!dhit);
			@(posedge CLK);
			dmem_ren <= 1'b0;
			dmem_wen <= 1'b0;
		end
	endtask

	initial begin
		void'($urandom(SEED));
		CLK        = 1'b0;
		nRST       = 1'b0;
		dmem_addr  = '0;
		dmem_ren   = 1'b0;
		dmem_wen   = 1'b0;
		dmem_store = '0;
		halt       = 1'b0;
		loaded     = 1'b0;
		if (!read_patterns()) begin
			$display("cannot open tests/dcache_patterns.txt");
			$display("Verification failed");
			$finish;
		end else begin
			n_ops  = op_kind.size();
			loaded = 1'b1;
			repeat (8) @(posedge CLK);
			nRST <= 1'b1;
			foreach (op_kind[i]) begin
				run_op(op_kind[i], op_addr[i], op_data[i]);
			end
			do @(posedge CLK); while (!chk_done);
			$display("tests %0d, errors %0d, assertion failures %0d",
				chk_tests, chk_errors, DUT.u_ctrl.props.fail_count);
			if (chk_errors == 0 && DUT.u_ctrl.props.fail_count == 0) begin
				$display("Verification passed");
			end else begin
				$display("Verification failed");
			end
			$finish;
		end
	end

	// watchdog, sized from the pattern count
	initial begin
		wait (loaded);
		repeat (40 * n_ops + 200) @(posedge CLK);
		$display("timeout: run did not finish within %0d cycles", 40 * n_ops + 200);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+design
design/dcache_pkg.sv
design/frame_store.sv
design/hit_check.sv
design/cache_controller.sv
design/dcache_top.sv
tests/dcache_properties.sv
tests/dcache_checker.sv
tests/tb_dcache.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dcache
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+100
PASS_MSG  = Verification passed

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/dcache_patterns.txt
# kind  address   store data (hex, data ignored for read and halt)
# set is address bits 5:3, tag is address bits 31:6
read  00000100 00000000
read  00000100 00000000
write 00000208 1111aaaa
read  00000208 00000000
read  0000020c 00000000
write 00000010 22220010
write 00000054 22220054
read  00000094 00000000
read  00000010 00000000
read  00000054 00000000
write 00000014 33330014
read  00000050 00000000
write 00000100 44440100
read  00000104 00000000
write 00000c38 55550c38
read  00000c38 00000000
halt  00000000 00000000
